// File: Makefile
SIM = obj_dir/Vjoypad_tb

all: run

$(SIM): joypad.f joypad_pkg.sv key_debounce.sv joypad_port.sv joypad_axil.sv \
	joypad_top.sv joypad_asserts.sv joypad_tb.sv
	verilator --binary --timing --assert --top-module joypad_tb -f joypad.f -o Vjoypad_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

lint:
	verilator --lint-only -Wall --top-module joypad_top \
		joypad_pkg.sv key_debounce.sv joypad_port.sv joypad_axil.sv joypad_top.sv
	verilator --lint-only --timing --assert --top-module joypad_tb -f joypad.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: joypad.f
joypad_pkg.sv
key_debounce.sv
joypad_port.sv
joypad_axil.sv
joypad_top.sv
joypad_asserts.sv
joypad_tb.sv

// File: joypad_asserts.sv
module joypad_asserts
	import joypad_pkg::*;
(
	input logic                    clk,
	input logic                    rst,
	input logic [7:0]              keys,
	input logic [AXI_ADDR_W-1:0]   awaddr,
	input logic                    awvalid,
	input logic                    awready,
	input logic [AXI_DATA_W-1:0]   wdata,
	input logic [AXI_DATA_W/8-1:0] wstrb,
	input logic                    wvalid,
	input logic                    wready,
	input logic [1:0]              bresp,
	input logic                    bvalid,
	input logic                    bready,
	input logic [AXI_ADDR_W-1:0]   araddr,
	input logic                    arvalid,
	input logic                    arready,
	input logic [AXI_DATA_W-1:0]   rdata,
	input logic [1:0]              rresp,
	input logic                    rvalid,
	input logic                    rready,
	input logic                    irq
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned err_count = 0;

	logic                    aw_got, w_got, seen_hs;
	logic [AXI_ADDR_W-1:0]   aw_q, wa;
	logic [AXI_DATA_W-1:0]   w_q, wd;
	logic [AXI_DATA_W/8-1:0] s_q, ws;
	logic                    aw_hs, w_hs, ar_hs, wr_done, clr_wr;
	joypad_reg_t             wreg, rreg;
	logic [1:0]              sel_sh, exp_bresp, exp_rresp;
	logic [7:0]              keys_sh, keys_q;
	logic [3:0]              hold, lines_sh, lines_q;
	logic                    fall_d, exp_flag;
	logic [AXI_DATA_W-1:0]   exp_rdata;

	// line i is pulled low by direction button i or action button i+4 when selected.
	function automatic logic [3:0] matrix(input logic [1:0] sel, input logic [7:0] k);
		logic [3:0] m;
		for (int i = 0; i < 4; i++) begin
			m[i] = !((!sel[0] && k[i]) || (!sel[1] && k[i+4]));
		end
		return m;
	endfunction

	assign aw_hs    = awvalid && awready;
	assign w_hs     = wvalid && wready;
	assign ar_hs    = arvalid && arready;
	assign wr_done  = (aw_got || aw_hs) && (w_got || w_hs);
	assign wa       = aw_got ? aw_q : awaddr;
	assign wd       = w_got ? w_q : wdata;
	assign ws       = w_got ? s_q : wstrb;
	assign wreg     = joypad_reg_t'(wa[3:2]);
	assign rreg     = joypad_reg_t'(araddr[3:2]);
	assign clr_wr   = wr_done && (wreg == REG_IRQ) && wd[0];
	assign lines_sh = matrix(sel_sh, keys_sh);

	always_ff @(posedge clk) begin
		if (rst) begin
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
			seen_hs  <= 1'b0;
			sel_sh   <= 2'b00;
			keys_sh  <= 8'h00;
			keys_q   <= 8'h00;
			hold     <= 4'h0;
			lines_q  <= 4'hf;
			fall_d   <= 1'b0;
			exp_flag <= 1'b0;
		end else begin
			if (aw_hs || w_hs || ar_hs) seen_hs <= 1'b1;
			if (wr_done) begin
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				if (wreg == REG_P1 && ws[0]) sel_sh <= wd[5:4];
			end else begin
				if (aw_hs) aw_got <= 1'b1;
				if (w_hs) w_got <= 1'b1;
			end
			// buttons count as held once unchanged for twelve cycles.
			keys_q <= keys;
			if (keys != keys_q) begin
				hold <= 4'h0;
			end else if (hold != 4'hf) begin
				hold <= hold + 4'h1;
			end
			if (keys == keys_q && hold == 4'ha) keys_sh <= keys;
			lines_q <= lines_sh;
			fall_d  <= |(lines_q & ~lines_sh);
			if (fall_d) begin
				exp_flag <= 1'b1;
			end else if (clr_wr) begin
				exp_flag <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs) aw_q <= awaddr;
		if (w_hs) begin
			w_q <= wdata;
			s_q <= wstrb;
		end
		if (wr_done) begin
			exp_bresp <= (wreg == REG_P1 || wreg == REG_IRQ || wreg == REG_KEYS) ? 2'b00 : 2'b10;
		end
		if (ar_hs) begin
			exp_rresp <= 2'b00;
			case (rreg)
				REG_P1:   exp_rdata <= {24'h0, 2'b11, sel_sh, lines_sh};
				REG_IRQ:  exp_rdata <= {31'h0, exp_flag};
				REG_KEYS: exp_rdata <= {24'h0, keys_sh};
				default: begin
					exp_rdata <= '0;
					exp_rresp <= 2'b10;
				end
			endcase
		end
	end

	a_reset_quiet: assert property (@(posedge clk) disable iff (rst)
		!seen_hs |-> !bvalid && !rvalid && !irq)
	else begin
		err_count++;
		$error("** Error bvalid/rvalid/irq: got 0x%h/0x%h/0x%h, expected 0x0 before any handshake",
			bvalid, rvalid, irq);
	end

	a_rvalid_rise: assert property (@(posedge clk) disable iff (rst) ar_hs |=> $rose(rvalid))
	else begin
		err_count++;
		$error("** Error rvalid: got 0x%h one cycle after AR handshake, expected 0x1", rvalid);
	end

	a_bvalid_rise: assert property (@(posedge clk) disable iff (rst) wr_done |=> $rose(bvalid))
	else begin
		err_count++;
		$error("** Error bvalid: got 0x%h one cycle after write accept, expected 0x1", bvalid);
	end

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else begin
		err_count++;
		$error("** Error rvalid/rdata: got 0x%h/0x%h, expected held 0x1/0x%h",
			rvalid, rdata, $past(rdata));
	end

	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else begin
		err_count++;
		$error("** Error bvalid/bresp: got 0x%h/0x%h, expected held 0x1/0x%h",
			bvalid, bresp, $past(bresp));
	end

	// no address or data is taken while a response waits on the bus.
	a_busy_ready: assert property (@(posedge clk) disable iff (rst)
		bvalid || rvalid |-> !awready && !wready && !arready)
	else begin
		err_count++;
		$error("** Error awready/wready/arready: got 0x%h/0x%h/0x%h, expected 0x0",
			awready, wready, arready);
	end

	a_rdata: assert property (@(posedge clk) disable iff (rst)
		$rose(rvalid) |-> rdata == exp_rdata && rresp == exp_rresp)
	else begin
		err_count++;
		$error("** Error rdata/rresp: got 0x%h/0x%h, expected 0x%h/0x%h",
			rdata, rresp, exp_rdata, exp_rresp);
	end

	a_bresp: assert property (@(posedge clk) disable iff (rst) $rose(bvalid) |-> bresp == exp_bresp)
	else begin
		err_count++;
		$error("** Error bresp: got 0x%h, expected 0x%h", bresp, exp_bresp);
	end

	a_irq_set: assert property (@(posedge clk) disable iff (rst) exp_flag |-> irq)
	else begin
		err_count++;
		$error("** Error irq: got 0x%h, expected 0x1", irq);
	end

	a_irq_clear: assert property (@(posedge clk) disable iff (rst) clr_wr |=> !irq)
	else begin
		err_count++;
		$error("** Error irq: got 0x%h after IRQ clear write, expected 0x0", irq);
	end

endmodule

// File: joypad_axil.sv
module joypad_axil
	import joypad_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [AXI_ADDR_W-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [AXI_DATA_W-1:0]   wdata,
	input  logic [AXI_DATA_W/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [AXI_ADDR_W-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [AXI_DATA_W-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	input  logic [7:0]              p1_value,
	input  logic [7:0]              keys_stable,
	input  logic                    irq,
	output logic                    sel_we,
	output logic [1:0]              sel_data,
	output logic                    irq_clr
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	axil_state_t state;

	logic                    aw_held, w_held;
	logic [AXI_ADDR_W-1:0]   aw_addr_q;
	logic [AXI_DATA_W-1:0]   w_data_q;
	logic [AXI_DATA_W/8-1:0] w_strb_q;
	logic                    aw_hs, w_hs, ar_hs, write_go;
	logic [AXI_ADDR_W-1:0]   wr_addr;
	logic [AXI_DATA_W-1:0]   wr_data;
	logic [AXI_DATA_W/8-1:0] wr_strb;
	joypad_reg_t             wr_reg, rd_reg;

	assign awready = (state == AXIL_IDLE) && !aw_held;
	assign wready  = (state == AXIL_IDLE) && !w_held;
	assign aw_hs   = awvalid && awready;
	assign w_hs    = wvalid && wready;

	// a write that completes this cycle takes priority over a read address.
	assign write_go = (aw_held || aw_hs) && (w_held || w_hs);
	assign arready  = (state == AXIL_IDLE) && !write_go;
	assign ar_hs    = arvalid && arready;

	assign bvalid = (state == AXIL_WRESP);
	assign rvalid = (state == AXIL_RDATA);

	// whichever half arrived earlier comes from its holding register.
	assign wr_addr = aw_held ? aw_addr_q : awaddr;
	assign wr_data = w_held ? w_data_q : wdata;
	assign wr_strb = w_held ? w_strb_q : wstrb;
	assign wr_reg  = joypad_reg_t'(wr_addr[AXI_ADDR_W-1:2]);
	assign rd_reg  = joypad_reg_t'(araddr[AXI_ADDR_W-1:2]);

	assign sel_we   = write_go && (wr_reg == REG_P1) && wr_strb[0];
	assign sel_data = wr_data[5:4];
	assign irq_clr  = write_go && (wr_reg == REG_IRQ) && wr_data[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= AXIL_IDLE;
			aw_held <= 1'b0;
			w_held  <= 1'b0;
		end else begin
			case (state)
				AXIL_IDLE: begin
					if (write_go) begin
						state   <= AXIL_WRESP;
						aw_held <= 1'b0;
						w_held  <= 1'b0;
					end else begin
						if (aw_hs) aw_held <= 1'b1;
						if (w_hs) w_held <= 1'b1;
						if (ar_hs) state <= AXIL_RDATA;
					end
				end
				AXIL_WRESP: if (bready) state <= AXIL_IDLE;
				AXIL_RDATA: if (rready) state <= AXIL_IDLE;
				default:    state <= AXIL_IDLE;
			endcase
		end
	end

	// payloads are only sampled at their handshakes and held until the response ends.
	always_ff @(posedge clk) begin
		if (aw_hs) aw_addr_q <= awaddr;
		if (w_hs) begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
		if (write_go) begin
			bresp <= (wr_addr[AXI_ADDR_W-1:2] == 2'd3) ? RESP_SLVERR : RESP_OKAY;
		end
		if (ar_hs) begin
			rresp <= RESP_OKAY;
			case (rd_reg)
				REG_P1:   rdata <= {{(AXI_DATA_W-8){1'b0}}, p1_value};
				REG_IRQ:  rdata <= {{(AXI_DATA_W-1){1'b0}}, irq};
				REG_KEYS: rdata <= {{(AXI_DATA_W-8){1'b0}}, keys_stable};
				default: begin
					rdata <= '0;
					rresp <= RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

// File: joypad_pkg.sv
package joypad_pkg;

	// AXI4-Lite bus geometry.
	localparam int AXI_ADDR_W = 4;
	localparam int AXI_DATA_W = 32;

	// word addresses, taken from byte address bits 3:2.
	// 0xC has no register behind it and is answered with SLVERR.
	typedef enum logic [1:0] {
		REG_P1   = 2'd0, // byte 0x0, select bits and matrix lines.
		REG_IRQ  = 2'd1, // byte 0x4, sticky falling-edge flag.
		REG_KEYS = 2'd2  // byte 0x8, debounced buttons.
	} joypad_reg_t;

	// bus slave FSM states.
	typedef enum logic [1:0] {
		AXIL_IDLE  = 2'd0,
		AXIL_WRESP = 2'd1,
		AXIL_RDATA = 2'd2
	} axil_state_t;

	// direction group, read on the matrix lines when P1 bit 4 is low.
	localparam logic [2:0] KEY_RIGHT  = 3'd0;
	localparam logic [2:0] KEY_LEFT   = 3'd1;
	localparam logic [2:0] KEY_UP     = 3'd2;
	localparam logic [2:0] KEY_DOWN   = 3'd3;

	// action group, read on the matrix lines when P1 bit 5 is low.
	localparam logic [2:0] KEY_A      = 3'd4;
	localparam logic [2:0] KEY_B      = 3'd5;
	localparam logic [2:0] KEY_SELECT = 3'd6;
	localparam logic [2:0] KEY_START  = 3'd7;

endpackage

// File: joypad_port.sv
module joypad_port
	import joypad_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] keys_stable,
	input  logic       sel_we,
	input  logic [1:0] sel_data,
	input  logic       irq_clr,
	output logic [7:0] p1_value,
	output logic       irq
);

	// sel[0] low selects the direction group, sel[1] low the action group.
	logic [1:0] sel;
	logic [3:0] dir_keys;
	logic [3:0] act_keys;
	logic [3:0] lines_next;
	logic [3:0] lines_prev;
	logic [3:0] fall;

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= 2'b00; // both groups selected out of reset.
		end else if (sel_we) begin
			sel <= sel_data;
		end
	end

	assign dir_keys = {
		keys_stable[KEY_DOWN],
		keys_stable[KEY_UP],
		keys_stable[KEY_LEFT],
		keys_stable[KEY_RIGHT]
	};

	assign act_keys = {
		keys_stable[KEY_START],
		keys_stable[KEY_SELECT],
		keys_stable[KEY_B],
		keys_stable[KEY_A]
	};

	// a line is pulled low by any pressed button of a selected group.
	assign lines_next = ~((dir_keys & {4{~sel[0]}}) | (act_keys & {4{~sel[1]}}));

	always_ff @(posedge clk) begin
		if (rst) begin
			p1_value   <= 8'hcf;
			lines_prev <= 4'hf;
		end else begin
			p1_value   <= {2'b11, sel, lines_next}; // upper two bits always read 1.
			lines_prev <= p1_value[3:0];
		end
	end

	assign fall = lines_prev & ~p1_value[3:0];

	// a new falling edge wins over a clear arriving in the same cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			irq <= 1'b0;
		end else if (|fall) begin
			irq <= 1'b1;
		end else if (irq_clr) begin
			irq <= 1'b0;
		end
	end

endmodule

// File: joypad_tb.sv
module joypad_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEB      = 8;
	localparam int N_TRANS  = 63;
	localparam int LIMIT    = N_TRANS * 64 + 16;

	logic        clk, rst;
	logic [7:0]  keys;
	logic [3:0]  awaddr, araddr;
	logic        awvalid, wvalid, bready, arvalid, rready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        awready, wready, bvalid, arready, rvalid, irq;
	logic [1:0]  bresp, rresp;
	logic [31:0] rdata;

	joypad_top #(
		.DEBOUNCE_CYCLES(DEB)
	) uut (
		.clk(clk), .rst(rst), .keys(keys),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.irq(irq)
	);

	bind joypad_top joypad_asserts u_asserts (.*);

	always #20 clk = ~clk;

	// AW and W start after independent random delays, so either may arrive first.
	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int  aw_delay, w_delay, b_delay, cyc;
		bit  aw_done, w_done, aw_hit, w_hit, hit;
		aw_delay = $urandom_range(0, 2);
		w_delay  = $urandom_range(0, 2);
		b_delay  = $urandom_range(0, 3);
		aw_done  = 1'b0;
		w_done   = 1'b0;
		cyc      = 0;
		while (!(aw_done && w_done)) begin
			if (!aw_done && cyc == aw_delay) begin
				awaddr  <= addr;
				awvalid <= 1'b1;
			end
			if (!w_done && cyc == w_delay) begin
				wdata  <= data;
				wstrb  <= strb;
				wvalid <= 1'b1;
			end
			@(negedge clk);
			aw_hit = awvalid && awready;
			w_hit  = wvalid && wready;
			@(posedge clk);
			if (aw_hit) begin
				awvalid <= 1'b0;
				aw_done = 1'b1;
			end
			if (w_hit) begin
				wvalid <= 1'b0;
				w_done = 1'b1;
			end
			cyc++;
		end
		repeat (b_delay) @(posedge clk); // response held back by a late bready.
		bready <= 1'b1;
		do begin
			@(negedge clk);
			hit = bvalid;
			@(posedge clk);
		end while (!hit);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr);
		int r_delay;
		bit hit;
		r_delay = $urandom_range(0, 3);
		araddr  <= addr;
		arvalid <= 1'b1;
		do begin
			@(negedge clk);
			hit = arready;
			@(posedge clk);
		end while (!hit);
		arvalid <= 1'b0;
		repeat (r_delay) @(posedge clk);
		rready <= 1'b1;
		do begin
			@(negedge clk);
			hit = rvalid;
			@(posedge clk);
		end while (!hit);
		rready <= 1'b0;
	endtask

	task automatic hold_keys(input logic [7:0] k);
		keys <= k;
		repeat (16) @(posedge clk);
	endtask

	always @(negedge clk) begin
		if (uut.u_asserts.err_count != 0) begin
			$display("TEST FAIL");
			$fatal(1, "the assertion checker reported an error");
		end
	end

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("TEST FAIL");
		$fatal(1, "timeout: the test sequence did not finish in time");
	end

	initial begin
		logic [7:0] pat, mask;
		int         len, r;
		void'($urandom(32'h57cb_bbde));
		clk     = 1'b0;
		rst     = 1'b1;
		keys    = 8'h00;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		axi_read(4'h0); // all lines high out of reset.

		for (int s = 0; s < 4; s++) begin
			axi_write(4'h0, 32'(s) << 4, 4'h1);
			for (int n = 0; n < 3; n++) begin
				hold_keys(8'($urandom));
				axi_read(4'h0);
				axi_read(4'h8);
			end
		end

		// short glitches between two equal held patterns, both groups selected.
		axi_write(4'h0, 32'h00, 4'h1);
		for (int n = 0; n < 4; n++) begin
			pat  = 8'($urandom) & 8'hef; // line 0 then follows button 0 alone.
			mask = 8'($urandom) | 8'h01;
			len  = $urandom_range(1, DEB - 1);
			hold_keys(pat);
			axi_write(4'h4, 32'h1, 4'hf);
			keys <= pat ^ mask;
			repeat (len) @(posedge clk);
			hold_keys(pat);
			axi_read(4'h8);
			axi_read(4'h4); // a glitch let through would have left a falling edge.
		end

		// direction group selected, action group off.
		for (int n = 0; n < 2; n++) begin
			axi_write(4'h0, 32'h20, 4'h1);
			hold_keys(8'h00);
			axi_write(4'h4, 32'h1, 4'hf);
			axi_read(4'h4);
			r   = $urandom_range(0, 3);
			pat = 8'h01 << r;
			hold_keys(pat);
			axi_read(4'h4);
			axi_write(4'h4, 32'h1, 4'hf);
			axi_read(4'h4);
			r = $urandom_range(0, 3);
			hold_keys(pat | (8'h10 << r));
			axi_read(4'h4);
			hold_keys(8'h00);
		end

		axi_read(4'hc);
		axi_write(4'hc, 32'h10, 4'hf);
		axi_read(4'h0);
		axi_write(4'h8, 32'hff, 4'hf);
		axi_read(4'h8);
		axi_write(4'h0, 32'h30, 4'h0); // no strobe, select bits keep their value.
		axi_read(4'h0);
		repeat (4) @(posedge clk);

		if (uut.u_asserts.err_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "assertion errors were reported");
		end
	end

endmodule

// File: joypad_top.sv
module joypad_top
	import joypad_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [7:0]              keys, // 1 = pressed.
	input  logic [AXI_ADDR_W-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [AXI_DATA_W-1:0]   wdata,
	input  logic [AXI_DATA_W/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [AXI_ADDR_W-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [AXI_DATA_W-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output logic                    irq
);

	logic [7:0] keys_stable;
	logic [7:0] p1_value;
	logic       sel_we;
	logic [1:0] sel_data;
	logic       irq_clr;

	key_debounce #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_debounce (
		.clk         (clk),
		.rst         (rst),
		.keys        (keys),
		.keys_stable (keys_stable)
	);

	joypad_port u_port (
		.clk         (clk),
		.rst         (rst),
		.keys_stable (keys_stable),
		.sel_we      (sel_we),
		.sel_data    (sel_data),
		.irq_clr     (irq_clr),
		.p1_value    (p1_value),
		.irq         (irq)
	);

	joypad_axil u_axil (
		.clk         (clk),
		.rst         (rst),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.p1_value    (p1_value),
		.keys_stable (keys_stable),
		.irq         (irq),
		.sel_we      (sel_we),
		.sel_data    (sel_data),
		.irq_clr     (irq_clr)
	);

endmodule

// File: key_debounce.sv
module key_debounce #(
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] keys,
	output logic [7:0] keys_stable
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

	// one counter per button, counting edges where the raw input disagrees.
	logic [CNT_W-1:0] cnt [8];
	logic [7:0]       differ;

	assign differ = keys ^ keys_stable;

	always_ff @(posedge clk) begin
		if (rst) begin
			keys_stable <= '0;
			for (int i = 0; i < 8; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 8; i++) begin
				if (!differ[i]) begin
					cnt[i] <= '0; // any agreement restarts the count.
				end else if (cnt[i] == CNT_LAST) begin
					// the input has disagreed long enough to be believed.
					keys_stable[i] <= keys[i];
					cnt[i]         <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule
